// File: design/ap_macros.svh
// audio pipeline macros: sample widths, frame size and accumulator sizing
`ifndef AP_MACROS_SVH
`define AP_MACROS_SVH

// ----------------------------------------------------------
// input samples
// ----------------------------------------------------------
// one unsigned mel band energy
`define MSIN_DATA_WIDTH 16

// ----------------------------------------------------------
// frame geometry
// ----------------------------------------------------------
// bins per frame, power of two for the shift divides
`define MS_ARRAY_WIDTH 16
`define MS_ARRAY_LOG2 4

// ----------------------------------------------------------
// statistics
// ----------------------------------------------------------
// sum of squared deviations needs 34 bits worst case
`define MS_DATA_WIDTH 40
// mean and std handed to the network layer
`define NN_DATA_WIDTH 16

`endif

// File: design/ap_norm_top.sv
// frame normalization top: collector, statistics and serializer in a chain
`timescale 1ns/1ps
`default_nettype none

`include "ap_macros.svh"

module ap_norm_top import ap_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mel_valid,
    input  mel_sample_t               mel_data,
    output logic                      feat_valid,
    output feat_t                     feat_data,
    output logic                      feat_last,
    output logic [`NN_DATA_WIDTH-1:0] frame_mean,
    output logic [`NN_DATA_WIDTH-1:0] frame_std
);

    // ----------------------------------------------------------
    // inter-stage wiring
    // ----------------------------------------------------------
    // collector to statistics
    logic                      frame_valid;
    mel_frame_t                frame;
    // statistics to serializer
    logic                      stats_valid;
    logic [`NN_DATA_WIDTH-1:0] stats_mean;
    logic [`NN_DATA_WIDTH-1:0] stats_std;
    mel_frame_t                stats_frame;

    // decode: samples into frames
    mel_frame_collect i_mel_frame_collect (
        .clk         (clk),
        .rst         (rst),
        .mel_valid   (mel_valid),
        .mel_data    (mel_data),
        .frame_valid (frame_valid),
        .frame       (frame)
    );

    // execute: mean and std, 18 cycles
    mean_std i_mean_std (
        .clk         (clk),
        .rst         (rst),
        .frame_valid (frame_valid),
        .frame       (frame),
        .stats_valid (stats_valid),
        .stats_mean  (stats_mean),
        .stats_std   (stats_std),
        .stats_frame (stats_frame)
    );

    // result: centred feature stream
    feature_serializer i_feature_serializer (
        .clk         (clk),
        .rst         (rst),
        .stats_valid (stats_valid),
        .stats_mean  (stats_mean),
        .stats_std   (stats_std),
        .stats_frame (stats_frame),
        .feat_valid  (feat_valid),
        .feat_data   (feat_data),
        .feat_last   (feat_last),
        .frame_mean  (frame_mean),
        .frame_std   (frame_std)
    );

endmodule

`default_nettype wire

// File: design/ap_pkg.sv
// audio pipeline package: sample, frame, accumulator and feature types
`default_nettype none

`include "ap_macros.svh"

package ap_pkg;

    // ----------------------------------------------------------
    // data types
    // ----------------------------------------------------------
    // one mel band energy, unsigned
    typedef logic [`MSIN_DATA_WIDTH-1:0] mel_sample_t;

    // full frame, bin 0 first
    typedef mel_sample_t mel_frame_t [`MS_ARRAY_WIDTH];

    // wide accumulator for sums and sums of squares
    typedef logic [`MS_DATA_WIDTH-1:0] ms_acc_t;

    // centred feature, one extra bit for the sign
    typedef logic signed [`MSIN_DATA_WIDTH:0] feat_t;

    // ----------------------------------------------------------
    // indexing
    // ----------------------------------------------------------
    // bin position inside a frame
    typedef logic [`MS_ARRAY_LOG2-1:0] bin_idx_t;

endpackage

`default_nettype wire

// File: design/feature_serializer.sv
// feature serializer: streams mean-centred bins with a last marker and held frame stats
`timescale 1ns/1ps
`default_nettype none

`include "ap_macros.svh"

module feature_serializer import ap_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stats_valid,
    input  logic [`NN_DATA_WIDTH-1:0] stats_mean,
    input  logic [`NN_DATA_WIDTH-1:0] stats_std,
    input  mel_frame_t                stats_frame,
    output logic                      feat_valid,
    output feat_t                     feat_data,
    output logic                      feat_last,
    output logic [`NN_DATA_WIDTH-1:0] frame_mean,
    output logic [`NN_DATA_WIDTH-1:0] frame_std
);

    // ----------------------------------------------------------
    // state
    // ----------------------------------------------------------
    // copy of the frame being streamed
    mel_frame_t hold_frame;
    // next bin to send
    bin_idx_t   bin_idx;

    // bin minus mean, always fits in 17 signed bits
    function automatic feat_t centre(input mel_sample_t bin,
                                     input logic [`NN_DATA_WIDTH-1:0] mean);
        return feat_t'($signed({1'b0, bin}) - $signed({1'b0, mean}));
    endfunction

    always_ff @(posedge clk) begin
        if (stats_valid) begin
            hold_frame <= stats_frame;
        end
    end

    // ----------------------------------------------------------
    // output sequencer
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            feat_valid <= 1'b0;
            feat_data  <= '0;
            feat_last  <= 1'b0;
            bin_idx    <= '0;
            frame_mean <= '0;
            frame_std  <= '0;
        end else if (stats_valid) begin
            // bin 0 straight from the input, stats latched with it
            frame_mean <= stats_mean;
            frame_std  <= stats_std;
            feat_valid <= 1'b1;
            feat_data  <= centre(stats_frame[0], stats_mean);
            feat_last  <= 1'b0;
            bin_idx    <= bin_idx_t'(1);
        end else if (feat_valid && !feat_last) begin
            // remaining bins from the held copy
            feat_data <= centre(hold_frame[bin_idx], frame_mean);
            feat_last <= (bin_idx == bin_idx_t'(`MS_ARRAY_WIDTH - 1));
            bin_idx   <= bin_idx + 1'b1;
        end else begin
            // idle between frames, stats stay held
            feat_valid <= 1'b0;
            feat_last  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/mean_std.sv
// frame statistics: one-cycle mean and variance, then a bit-serial integer square root
`timescale 1ns/1ps
`default_nettype none

`include "ap_macros.svh"

module mean_std import ap_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      frame_valid,
    input  mel_frame_t                frame,
    output logic                      stats_valid,
    output logic [`NN_DATA_WIDTH-1:0] stats_mean,
    output logic [`NN_DATA_WIDTH-1:0] stats_std,
    output mel_frame_t                stats_frame
);

    // ----------------------------------------------------------
    // signals
    // ----------------------------------------------------------
    // first stage, combinational
    ms_acc_t                          sum_c;
    ms_acc_t                          mean_full_c;
    ms_acc_t                          sq_sum_c;
    ms_acc_t                          var_full_c;
    logic [`NN_DATA_WIDTH-1:0]        mean_c;
    logic [`MSIN_DATA_WIDTH-1:0]      abs_dev;
    logic [2*`MSIN_DATA_WIDTH-1:0]    dev_sq;

    // first stage registers
    logic                             s1_pend;
    logic [`NN_DATA_WIDTH-1:0]        s1_mean;
    logic [2*`NN_DATA_WIDTH-1:0]      s1_var;
    mel_frame_t                       s1_frame;

    // square root stage
    logic                             sq_load;
    logic                             sq_busy;
    logic                             sq_done;
    logic [$clog2(`NN_DATA_WIDTH)-1:0] sq_step;
    logic [2*`NN_DATA_WIDTH-1:0]      sq_rad;
    logic [`NN_DATA_WIDTH+1:0]        sq_rem;
    logic [`NN_DATA_WIDTH-1:0]        sq_root;
    logic [`NN_DATA_WIDTH-1:0]        sq_mean;
    mel_frame_t                       sq_frame;

    // one root step
    logic [2*`NN_DATA_WIDTH-1:0]      src_rad;
    logic [`NN_DATA_WIDTH+1:0]        src_rem;
    logic [`NN_DATA_WIDTH-1:0]        src_root;
    logic [`NN_DATA_WIDTH+3:0]        rem_sh;
    logic [`NN_DATA_WIDTH+3:0]        trial;
    logic [`NN_DATA_WIDTH+3:0]        rem_diff;
    logic [2*`NN_DATA_WIDTH-1:0]      rad_nxt;
    logic [`NN_DATA_WIDTH+1:0]        rem_nxt;
    logic [`NN_DATA_WIDTH-1:0]        root_nxt;

    // ----------------------------------------------------------
    // stage 1: mean and variance
    // ----------------------------------------------------------
    always_comb begin
        sum_c    = '0;
        sq_sum_c = '0;
        abs_dev  = '0;
        dev_sq   = '0;

        // plain sum of all bins
        for (int i = 0; i < `MS_ARRAY_WIDTH; i++) begin
            sum_c = sum_c + ms_acc_t'(frame[i]);
        end

        // floor divide by the frame size
        mean_full_c = sum_c >> `MS_ARRAY_LOG2;
        mean_c      = mean_full_c[`NN_DATA_WIDTH-1:0];

        // squared distance from the mean, unsigned magnitude
        for (int i = 0; i < `MS_ARRAY_WIDTH; i++) begin
            abs_dev  = (frame[i] >= mean_c) ? frame[i] - mean_c : mean_c - frame[i];
            dev_sq   = abs_dev * abs_dev;
            sq_sum_c = sq_sum_c + ms_acc_t'(dev_sq);
        end

        // variance stays below 2^30 for 16-bit bins
        var_full_c = sq_sum_c >> `MS_ARRAY_LOG2;
    end

    // root stage takes the pending frame once it is idle
    assign sq_load = s1_pend && !sq_busy;

    // ----------------------------------------------------------
    // stage 2: restoring square root step
    // ----------------------------------------------------------
    always_comb begin
        // the load cycle already decides the top root bit
        src_rad  = sq_load ? s1_var : sq_rad;
        src_rem  = sq_load ? '0 : sq_rem;
        src_root = sq_load ? '0 : sq_root;

        // bring down the next two radicand bits
        rem_sh   = {src_rem, src_rad[2*`NN_DATA_WIDTH-1 -: 2]};
        trial    = {2'b00, src_root, 2'b01};
        rem_diff = rem_sh - trial;
        rad_nxt  = {src_rad[2*`NN_DATA_WIDTH-3:0], 2'b00};

        if (rem_sh >= trial) begin
            rem_nxt  = rem_diff[`NN_DATA_WIDTH+1:0];
            root_nxt = {src_root[`NN_DATA_WIDTH-2:0], 1'b1};
        end else begin
            rem_nxt  = rem_sh[`NN_DATA_WIDTH+1:0];
            root_nxt = {src_root[`NN_DATA_WIDTH-2:0], 1'b0};
        end
    end

    // ----------------------------------------------------------
    // payload registers
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (frame_valid) begin
            s1_mean  <= mean_c;
            s1_var   <= var_full_c[2*`NN_DATA_WIDTH-1:0];
            s1_frame <= frame;
        end
        // frame and mean ride along with the root
        if (sq_load) begin
            sq_mean  <= s1_mean;
            sq_frame <= s1_frame;
        end
        if (sq_load || sq_busy) begin
            sq_rad  <= rad_nxt;
            sq_rem  <= rem_nxt;
            sq_root <= root_nxt;
        end
    end

    // ----------------------------------------------------------
    // control and outputs
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_pend     <= 1'b0;
            sq_busy     <= 1'b0;
            sq_done     <= 1'b0;
            sq_step     <= '0;
            stats_valid <= 1'b0;
            stats_mean  <= '0;
            stats_std   <= '0;
            stats_frame <= '{default: '0};
        end else begin
            // one frame parked between the stages
            if (frame_valid) begin
                s1_pend <= 1'b1;
            end else if (sq_load) begin
                s1_pend <= 1'b0;
            end

            // 16 steps: load does step 0, busy does the rest
            sq_done <= 1'b0;
            if (sq_load) begin
                sq_busy <= 1'b1;
                sq_step <= 1;
            end else if (sq_busy) begin
                sq_step <= sq_step + 1'b1;
                if (sq_step == (`NN_DATA_WIDTH - 1)) begin
                    sq_busy <= 1'b0;
                    sq_done <= 1'b1;
                end
            end

            // results 18 cycles after frame_valid
            stats_valid <= sq_done;
            if (sq_done) begin
                stats_mean  <= sq_mean;
                stats_std   <= sq_root;
                stats_frame <= sq_frame;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mel_frame_collect.sv
// mel frame collector gathering strobed mel samples into a double-buffered frame
`timescale 1ns/1ps
`default_nettype none

`include "ap_macros.svh"

module mel_frame_collect import ap_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        mel_valid,
    input  mel_sample_t mel_data,
    output logic        frame_valid,
    output mel_frame_t  frame
);

    // ----------------------------------------------------------
    // state
    // ----------------------------------------------------------
    // write position of the next sample
    bin_idx_t   bin_cnt;
    // buffer being filled
    mel_frame_t fill_buf;
    // last bin written on the previous edge
    logic       fill_done;
    logic       last_bin;

    // counter sits on the final bin
    assign last_bin = (bin_cnt == bin_idx_t'(`MS_ARRAY_WIDTH - 1));

    // ----------------------------------------------------------
    // fill buffer
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        // sample k lands in bin k
        if (mel_valid) begin
            fill_buf[bin_cnt] <= mel_data;
        end
    end

    // ----------------------------------------------------------
    // bin counter and frame hand-off
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bin_cnt     <= '0;
            fill_done   <= 1'b0;
            frame_valid <= 1'b0;
            frame       <= '{default: '0};
        end else begin
            // wraps on its own since the frame size is a power of two
            if (mel_valid) begin
                bin_cnt <= bin_cnt + 1'b1;
            end

            // flag the completed fill one edge before the copy
            fill_done <= mel_valid && last_bin;

            // one-cycle strobe toward the statistics stage
            frame_valid <= fill_done;

            // copy reads the old buffer so bin 0 of the
            // next frame may be written on this same edge
            if (fill_done) begin
                frame <= fill_buf;
            end
        end
    end

    // frame register stays put until the next completion
    // fill_buf collects while frame holds the last complete frame

endmodule

`default_nettype wire

// File: project.f
+incdir+design
design/ap_pkg.sv
design/mel_frame_collect.sv
design/mean_std.sv
design/feature_serializer.sv
design/ap_norm_top.sv
sim/tb_ap_norm.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module tb_ap_norm -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or run error, see build.log and sim.log"; exit 1; }

grep -q "FAIL: see errors above" sim.log \
    && { echo "simulation failed, see sim.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// File: sim/tb_ap_norm.sv
// frame normalization testbench: random mel frames against a mean, variance and sqrt model
`timescale 1ns/1ps
`default_nettype none

`include "ap_macros.svh"

module tb_ap_norm import ap_pkg::*;;

    // ----------------------------------------------------------
    // run length
    // ----------------------------------------------------------
    localparam int NUM_FRAMES = 15;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * (`MS_ARRAY_WIDTH * 4 + 40) + 500;
    localparam int LATENCY = 20;

    logic                      clk;
    logic                      rst;
    logic                      mel_valid;
    mel_sample_t               mel_data;
    logic                      feat_valid;
    feat_t                     feat_data;
    logic                      feat_last;
    logic [`NN_DATA_WIDTH-1:0] frame_mean;
    logic [`NN_DATA_WIDTH-1:0] frame_std;

    // expected stream, one entry per feature
    feat_t                     exp_data_q [$];
    logic                      exp_last_q [$];
    logic [`NN_DATA_WIDTH-1:0] exp_mean_q [$];
    logic [`NN_DATA_WIDTH-1:0] exp_std_q [$];
    // posedge count that accepted each frame's last sample
    int                        accept_q [$];

    logic [31:0] lcg_state;
    int          cyc;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    logic        mid_frame;

    ap_norm_top i_ap_norm_top (
        .clk        (clk),
        .rst        (rst),
        .mel_valid  (mel_valid),
        .mel_data   (mel_data),
        .feat_valid (feat_valid),
        .feat_data  (feat_data),
        .feat_last  (feat_last),
        .frame_mean (frame_mean),
        .frame_std  (frame_std)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ----------------------------------------------------------
    // reference model
    // ----------------------------------------------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // binary search, invariant lo*lo <= v < hi*hi
    function automatic longint floor_sqrt(input longint v);
        longint lo;
        longint hi;
        longint mid;
        lo = 0;
        hi = 65536;
        while (hi - lo > 1) begin
            mid = (lo + hi) / 2;
            if (mid * mid <= v) begin
                lo = mid;
            end else begin
                hi = mid;
            end
        end
        return lo;
    endfunction

    task automatic model_frame(input mel_frame_t f);
        longint b;
        longint sum;
        longint mean;
        longint sq;
        longint sd;
        sum = 0;
        sq  = 0;
        for (int i = 0; i < `MS_ARRAY_WIDTH; i++) begin
            b   = f[i];
            sum = sum + b;
        end
        // floor, everything non-negative
        mean = sum / `MS_ARRAY_WIDTH;
        for (int i = 0; i < `MS_ARRAY_WIDTH; i++) begin
            b  = f[i];
            sq = sq + (b - mean) * (b - mean);
        end
        sd = floor_sqrt(sq / `MS_ARRAY_WIDTH);
        for (int i = 0; i < `MS_ARRAY_WIDTH; i++) begin
            b = f[i];
            exp_data_q.push_back(feat_t'(b - mean));
            exp_last_q.push_back(i == `MS_ARRAY_WIDTH - 1);
            exp_mean_q.push_back(mean[`NN_DATA_WIDTH-1:0]);
            exp_std_q.push_back(sd[`NN_DATA_WIDTH-1:0]);
        end
    endtask

    // ----------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------
    task automatic random_frame(output mel_frame_t f);
        logic [31:0] r;
        for (int i = 0; i < `MS_ARRAY_WIDTH; i++) begin
            r    = next_rand();
            f[i] = r[31:16];
        end
    endtask

    // called on a falling edge, returns on one; max_gap 0 means no idle cycles
    task automatic send_frame(input mel_frame_t f, input int max_gap);
        int gap;
        for (int i = 0; i < `MS_ARRAY_WIDTH; i++) begin
            gap = (max_gap > 0) ? int'((next_rand() >> 16) % (max_gap + 1)) : 0;
            if (gap > 0) begin
                mel_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            mel_valid = 1'b1;
            mel_data  = f[i];
            if (i == `MS_ARRAY_WIDTH - 1) begin
                accept_q.push_back(cyc + 1);
            end
            @(negedge clk);
        end
        mel_valid = 1'b0;
        model_frame(f);
    endtask

    task automatic check_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            assert (feat_valid === 1'b0 && feat_last === 1'b0) else begin
                $display("CHECK FAILED feat_valid/feat_last: got 0x%h/0x%h expected 0x0/0x0",
                         feat_valid, feat_last);
                errors++;
            end
            assert (frame_mean === '0 && frame_std === '0) else begin
                $display("CHECK FAILED frame_mean/frame_std: got 0x%h/0x%h expected 0x0/0x0",
                         frame_mean, frame_std);
                errors++;
            end
        end
    endtask

    // bounded wait for every queued feature to come out
    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_data_q.size() != 0 || feat_valid) && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (exp_data_q.size() != 0) begin
            $display("%0d expected features never appeared", exp_data_q.size());
            errors = errors + 1;
            exp_data_q.delete();
            exp_last_q.delete();
            exp_mean_q.delete();
            exp_std_q.delete();
            accept_q.delete();
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        wait_drain();
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    // ----------------------------------------------------------
    // output checker, outputs are stable on the falling edge
    // ----------------------------------------------------------
    always @(negedge clk) begin : check_features
        feat_t                     e_data;
        logic                      e_last;
        logic [`NN_DATA_WIDTH-1:0] e_mean;
        logic [`NN_DATA_WIDTH-1:0] e_std;
        int                        lat;
        if (!rst && feat_valid) begin
            if (exp_data_q.size() == 0) begin
                $display("feature appeared with nothing expected at %0t", $time);
                errors = errors + 1;
            end else begin
                // first bin of a frame, measure from the last accepted sample
                if (!mid_frame && accept_q.size() != 0) begin
                    lat = cyc - accept_q.pop_front();
                    assert (lat == LATENCY) else begin
                        $display("first feature came %0d cycles after the last sample, not %0d",
                                 lat, LATENCY);
                        errors = errors + 1;
                    end
                end
                e_data = exp_data_q.pop_front();
                e_last = exp_last_q.pop_front();
                e_mean = exp_mean_q.pop_front();
                e_std  = exp_std_q.pop_front();
                assert (feat_data === e_data) else begin
                    $display("CHECK FAILED feat_data: got 0x%h expected 0x%h", feat_data, e_data);
                    errors = errors + 1;
                end
                assert (feat_last === e_last) else begin
                    $display("CHECK FAILED feat_last: got 0x%h expected 0x%h", feat_last, e_last);
                    errors = errors + 1;
                end
                assert (frame_mean === e_mean) else begin
                    $display("CHECK FAILED frame_mean: got 0x%h expected 0x%h", frame_mean, e_mean);
                    errors = errors + 1;
                end
                assert (frame_std === e_std) else begin
                    $display("CHECK FAILED frame_std: got 0x%h expected 0x%h", frame_std, e_std);
                    errors = errors + 1;
                end
            end
            mid_frame = !feat_last;
        end else if (!rst) begin
            assert (!mid_frame) else begin
                $display("feature stream stopped before the last bin at %0t", $time);
                errors = errors + 1;
            end
            assert (feat_last === 1'b0) else begin
                $display("CHECK FAILED feat_last: got 0x%h expected 0x0", feat_last);
                errors = errors + 1;
            end
            mid_frame = 1'b0;
        end
    end

    // ----------------------------------------------------------
    // watchdog
    // ----------------------------------------------------------
    initial begin
        #(WATCHDOG_CYCLES * 20);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    // ----------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------
    initial begin
        mel_frame_t f;
        mel_frame_t keep;
        int         e0;
        clk          = 1'b0;
        rst          = 1'b1;
        mel_valid    = 1'b0;
        mel_data     = '0;
        lcg_state    = 32'h5330_d4e4;
        cyc          = 0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        mid_frame    = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        e0 = errors;
        check_idle(30);
        end_test("idle after reset", e0);

        // constant frame, std 0 and all features 0
        e0 = errors;
        f  = '{default: 16'h1234};
        send_frame(f, 0);
        end_test("constant frame", e0);

        // largest variance, then random full range
        e0 = errors;
        for (int i = 0; i < `MS_ARRAY_WIDTH; i++) begin
            f[i] = (i % 2 == 0) ? 16'h0000 : 16'hffff;
        end
        send_frame(f, 0);
        repeat (6) begin
            random_frame(f);
            send_frame(f, 0);
            wait_drain();
        end
        end_test("random stats and max variance", e0);

        // ramp across the range, negative and positive features
        e0 = errors;
        for (int i = 0; i < `MS_ARRAY_WIDTH; i++) begin
            f[i] = mel_sample_t'(i * 4000);
        end
        send_frame(f, 0);
        end_test("signed feature order", e0);

        // two frames in flight through the statistics stage
        e0 = errors;
        repeat (4) begin
            random_frame(f);
            send_frame(f, 0);
        end
        end_test("back to back frames", e0);

        // same samples with and without idle gaps
        e0 = errors;
        random_frame(keep);
        send_frame(keep, 3);
        wait_drain();
        send_frame(keep, 0);
        end_test("gapped input", e0);

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
